// ==== Makefile ====
# Verilator build and run of the video switch testbench

SRCS = $(wildcard rtl/*.sv tests/*.sv)

.PHONY: all run lint clean

all: run

obj_dir/Vvideo_switch_tb: $(SRCS) project.f
	verilator --binary --timing --assert -j 0 --top-module video_switch_tb -f project.f

run: obj_dir/Vvideo_switch_tb
	./obj_dir/Vvideo_switch_tb

lint:
	verilator --lint-only -Wall --timing --top-module video_switch_tb -f project.f

clean:
	rm -rf obj_dir

// ==== project.f ====
rtl/vswitch_pkg.sv
rtl/video_timing_cfg.sv
rtl/video_sync_chan.sv
rtl/video_out_switch.sv
rtl/video_switch.sv
tests/clk_gen.sv
tests/video_switch_sva.sv
tests/video_switch_tb.sv

// ==== rtl/video_out_switch.sv ====
/*
 * Frame-aligned source switch and output register.
 * The displayed source changes only between frames. While switching the
 * picture is black, or blue when the requested source is dead.
 * A dead requested source is taken over at once, but the switch stays
 * active until that source delivers a full vsync cycle again.
 * ce_pix follows the selected channel's strobe one cycle later.
 */
`timescale 1ns/1ps

module video_out_switch import vswitch_pkg::*; (
   input  logic      clk_vdc,
   input  logic      pll_reset,
   input  logic      mode,
   input  chan_out_t chan [NUM_CHAN],
   output vid_out_t  vid,
   output logic      ce_pix,
   output logic      selected
);

   sw_state_t           state;
   logic                switching;
   logic [NUM_CHAN-1:0] vs;
   logic [NUM_CHAN-1:0] ok;
   logic                blue_q;
   vid_out_t            pix_q;

   always_comb begin
      for (int k = 0; k < NUM_CHAN; k++) begin
         vs[k] = chan[k].vsync;
         ok[k] = chan[k].valid;
      end
   end

   always_ff @(posedge clk_vdc) begin
      if (pll_reset) begin
         state     <= SW_OLD_LOW;
         switching <= 1'b1;
         selected  <= 1'b0;
      end else begin
         case (state)
            SW_IDLE: begin
               if (mode != selected && (vs[selected] || !ok[selected])) begin
                  switching <= 1'b1;
                  state     <= SW_OLD_LOW;
               end
            end
            SW_OLD_LOW: begin
               if (!vs[selected] || !ok[selected]) begin
                  state <= SW_OLD_HIGH;
               end
            end
            SW_OLD_HIGH: begin
               if (vs[selected] || !ok[selected]) begin
                  state <= SW_WAIT_NEW;  // Old frame finished
               end
            end
            SW_WAIT_NEW: begin
               if (vs[mode] || !ok[mode]) begin
                  selected <= mode;
                  state    <= SW_NEW_LOW;
               end
            end
            SW_NEW_LOW: begin
               if (!vs[selected]) begin
                  state <= SW_NEW_HIGH;
               end
            end
            SW_NEW_HIGH: begin
               if (vs[selected]) begin
                  switching <= 1'b0;
                  state     <= SW_IDLE;
               end
            end
            default: begin
               state <= SW_OLD_LOW;
            end
         endcase
      end
   end

   always_ff @(posedge clk_vdc) begin
      if (pll_reset) begin
         ce_pix <= 1'b0;
         blue_q <= 1'b0;
         pix_q  <= '0;
      end else begin
         ce_pix            <= chan[selected].ce;
         blue_q            <= !ok[mode];
         pix_q.vga_disable <= !ok[selected];  // Tracks a dead source without strobes
         if (chan[selected].ce) begin
            pix_q.hsync  <= chan[selected].hsync;
            pix_q.vsync  <= chan[selected].vsync;
            pix_q.hblank <= chan[selected].hblank;
            pix_q.vblank <= chan[selected].vblank;
            pix_q.r      <= chan[selected].r;
            pix_q.g      <= chan[selected].g;
            pix_q.b      <= chan[selected].b;
         end
      end
   end

   always_comb begin
      vid = pix_q;
      if (switching) begin
         vid.r = '0;
         vid.g = '0;
         vid.b = blue_q ? BLUE_SCREEN : '0;
      end
   end

endmodule

// ==== rtl/video_switch.sv ====
/*
 * Two-source video switch top level.
 * Everything runs on clk_vdc; both sources must already be synchronous to it.
 * mode = 1 requests channel 1 (40-column), mode = 0 channel 0 (80-column).
 * Source strobe to ce_pix is 2 cycles; no interlace or field handling.
 */
`timescale 1ns/1ps

module video_switch import vswitch_pkg::*; (
   input  logic     clk_vdc,
   input  logic     pll_reset,
   input  logic     mode,
   input  logic     wide,
   input  logic     vdc_position,
   input  src_in_t  src [NUM_CHAN],
   output vid_out_t vid,
   output logic     ce_pix,
   output logic     selected
);

   hshift_t   shift [NUM_CHAN];
   chan_out_t chan  [NUM_CHAN];

   video_timing_cfg u_timing_cfg (
      .clk_vdc      (clk_vdc),
      .pll_reset    (pll_reset),
      .wide         (wide),
      .vdc_position (vdc_position),
      .vsync0       (chan[0].vsync),  // Frame start of the 80-column source
      .shift        (shift)
   );

   generate
      for (genvar k = 0; k < NUM_CHAN; k++) begin : g_chan
         video_sync_chan u_sync_chan (
            .clk_vdc   (clk_vdc),
            .pll_reset (pll_reset),
            .src       (src[k]),
            .shift     (shift[k]),
            .chan      (chan[k])
         );
      end
   endgenerate

   video_out_switch u_out_switch (
      .clk_vdc   (clk_vdc),
      .pll_reset (pll_reset),
      .mode      (mode),
      .chan      (chan),
      .vid       (vid),
      .ce_pix    (ce_pix),
      .selected  (selected)
   );

endmodule

// ==== rtl/video_sync_chan.sv ====
/*
 * One video source channel.
 * Blanking is rebuilt from the sync edges; the right edge uses the length of
 * the previous complete line, so the first line after reset has no right
 * blanking. The source is marked invalid after LINE_TIMEOUT cycles without an
 * hsync rising edge. All outputs are registered with a fixed 1 cycle latency.
 */
`timescale 1ns/1ps

module video_sync_chan import vswitch_pkg::*; (
   input  logic      clk_vdc,
   input  logic      pll_reset,
   input  src_in_t   src,
   input  hshift_t   shift,
   output chan_out_t chan
);

   logic     hs_rise;
   logic     vs_rise;
   hcount_t  pix_cnt;
   hcount_t  pix_idx;
   hcount_t  pix_next;
   hcount_t  line_len;
   hcount_t  right_edge;
   vcount_t  line_cnt;
   vcount_t  line_idx;
   timeout_t tmo_cnt;
   logic     timed_out;
   logic     hblank_now;
   logic     vblank_now;
   logic     valid_now;

   // The registered syncs double as the previous input sample
   assign hs_rise = src.hsync && !chan.hsync;
   assign vs_rise = src.vsync && !chan.vsync;

   always_comb begin
      pix_idx = hs_rise ? '0 : pix_cnt;
      if (src.ce && pix_idx != '1) begin
         pix_next = pix_idx + 1'b1;
      end else begin
         pix_next = pix_idx;
      end

      right_edge = line_len - shift.right;
      hblank_now = (pix_idx < shift.left) ||
                   (line_len > shift.right && pix_idx >= right_edge);
   end

   always_comb begin
      if (vs_rise) begin
         line_idx = '0;
      end else if (hs_rise && line_cnt != '1) begin
         line_idx = line_cnt + 1'b1;  // Saturates so vblank does not repeat
      end else begin
         line_idx = line_cnt;
      end
      vblank_now = line_idx < vcount_t'(VBLANK_LINES);
   end

   assign timed_out = tmo_cnt == timeout_t'(LINE_TIMEOUT - 1);
   assign valid_now = hs_rise || (chan.valid && !timed_out);

   always_ff @(posedge clk_vdc) begin
      if (pll_reset) begin
         pix_cnt  <= '0;
         line_len <= '0;
         line_cnt <= '1;  // No vblank until the first vsync
         tmo_cnt  <= '0;
         chan     <= '0;
      end else begin
         pix_cnt  <= pix_next;
         line_cnt <= line_idx;
         if (hs_rise) begin
            line_len <= pix_cnt;  // Strobes in the line just ended
         end

         if (hs_rise) begin
            tmo_cnt <= '0;
         end else if (!timed_out) begin
            tmo_cnt <= tmo_cnt + 1'b1;
         end

         chan.hsync  <= src.hsync;
         chan.vsync  <= src.vsync;
         chan.hblank <= hblank_now;
         chan.vblank <= vblank_now;
         chan.ce     <= src.ce;
         chan.valid  <= valid_now;
         chan.r      <= src.r;
         chan.g      <= src.g;
         chan.b      <= src.b;
      end
   end

endmodule

// ==== rtl/video_timing_cfg.sv ====
/*
 * Per-channel horizontal blanking shifts.
 * The position option only affects channel 0 and is sampled at the rising
 * edge of channel 0's output vsync, so a change applies from the next frame.
 * Shifts are registered and reach the channels two cycles after that edge.
 */
`timescale 1ns/1ps

module video_timing_cfg import vswitch_pkg::*; (
   input  logic    clk_vdc,
   input  logic    pll_reset,
   input  logic    wide,
   input  logic    vdc_position,
   input  logic    vsync0,
   output hshift_t shift [NUM_CHAN]
);

   logic    vsync0_d;
   logic    pos_q;
   hshift_t base;
   hshift_t pos_ofs;

   always_comb begin
      if (wide) begin
         base = '{left: SHIFT_L_WIDE, right: SHIFT_R_WIDE};
      end else begin
         base = '{left: SHIFT_L_NARROW, right: SHIFT_R_NARROW};
      end

      if (pos_q) begin
         pos_ofs = '{left: POS1_L_OFS, right: POS1_R_OFS};
      end else begin
         pos_ofs = '{left: POS_L_OFS, right: POS_R_OFS};
      end
   end

   always_ff @(posedge clk_vdc) begin
      if (pll_reset) begin
         vsync0_d <= 1'b0;
         pos_q    <= 1'b0;
         shift[0] <= '0;
         shift[1] <= '0;
      end else begin
         vsync0_d <= vsync0;
         if (vsync0 && !vsync0_d) begin
            pos_q <= vdc_position;  // Frame start of channel 0
         end

         shift[0].left  <= base.left + pos_ofs.left;
         shift[0].right <= base.right + pos_ofs.right;
         shift[1]       <= base;
      end
   end

endmodule

// ==== rtl/vswitch_pkg.sv ====
/*
 * Shared types and constants for the two-source video switch.
 * Channel 0 is the 80-column source and channel 1 the 40-column source.
 * Shift values are in pixel strobes of the owning channel.
 */
package vswitch_pkg;

   typedef logic [11:0] hcount_t;   // Pixel index, line length or shift
   typedef logic [9:0]  vcount_t;   // Line index since vsync
   typedef logic [15:0] timeout_t;  // Cycles since the last hsync edge
   typedef logic [7:0]  color_t;

   typedef struct packed {
      logic   hsync;
      logic   vsync;
      logic   ce;
      color_t r;
      color_t g;
      color_t b;
   } src_in_t;

   typedef struct packed {
      hcount_t left;   // Blanked after hsync rise
      hcount_t right;  // Blanked before line end
   } hshift_t;

   typedef struct packed {
      logic   hsync;
      logic   vsync;
      logic   hblank;
      logic   vblank;
      logic   ce;
      logic   valid;
      color_t r;
      color_t g;
      color_t b;
   } chan_out_t;

   typedef struct packed {
      logic   hsync;
      logic   vsync;
      logic   hblank;
      logic   vblank;
      logic   vga_disable;
      color_t r;
      color_t g;
      color_t b;
   } vid_out_t;

   typedef enum logic [2:0] {
      SW_IDLE,
      SW_OLD_LOW,
      SW_OLD_HIGH,
      SW_WAIT_NEW,
      SW_NEW_LOW,
      SW_NEW_HIGH
   } sw_state_t;

   localparam int NUM_CHAN = 2;

   localparam hcount_t SHIFT_L_NARROW = 12'd56;
   localparam hcount_t SHIFT_R_NARROW = 12'd15;
   localparam hcount_t SHIFT_L_WIDE   = 12'd141;
   localparam hcount_t SHIFT_R_WIDE   = 12'd95;

   // Channel 0 only, selected by the latched position option
   localparam hcount_t POS_L_OFS  = 12'd180;
   localparam hcount_t POS_R_OFS  = 12'd28;
   localparam hcount_t POS1_L_OFS = 12'd100;
   localparam hcount_t POS1_R_OFS = 12'd0;

   localparam int     VBLANK_LINES = 2;
   localparam int     LINE_TIMEOUT = 4096;
   localparam color_t BLUE_SCREEN  = 8'hCF;

endpackage

// ==== tests/clk_gen.sv ====
/*
 * Testbench clock and reset.
 * 10 ns clock; reset is held for the first 10 rising edges.
 */
`timescale 1ns/1ps

module clk_gen (
   output logic clk_vdc,
   output logic pll_reset
);

   initial begin
      clk_vdc = 1'b0;
      forever #5 clk_vdc = ~clk_vdc;
   end

   initial begin
      pll_reset = 1'b1;
      repeat (10) @(posedge clk_vdc);
      pll_reset <= 1'b0;
   end

endmodule

// ==== tests/video_switch_sva.sv ====
/*
 * Concurrent checks on the source switch, bound into video_out_switch.
 * Connects to the internal switching level by name.
 */
`timescale 1ns/1ps

module video_switch_sva import vswitch_pkg::*; (
   input logic     clk_vdc,
   input logic     pll_reset,
   input logic     switching,
   input logic     selected,
   input logic     ce_pix,
   input vid_out_t vid
);

   // Source swap only inside a switch sequence
   a_sel_in_switch: assert property (@(posedge clk_vdc) disable iff (pll_reset)
      (selected != $past(selected)) |-> ($past(switching) && switching))
      else $error("selected changed outside a switch sequence");

   // Black or blue picture while switching
   a_black_rg: assert property (@(posedge clk_vdc) disable iff (pll_reset)
      switching |-> (vid.r == '0 && vid.g == '0))
      else $error("r or g not zero while switching");

   a_ce_pulse: assert property (@(posedge clk_vdc) disable iff (pll_reset)
      ce_pix |=> !ce_pix)
      else $error("ce_pix high for two cycles");

endmodule

bind video_out_switch video_switch_sva u_switch_sva (
   .clk_vdc   (clk_vdc),
   .pll_reset (pll_reset),
   .switching (switching),
   .selected  (selected),
   .ce_pix    (ce_pix),
   .vid       (vid)
);

// ==== tests/video_switch_tb.sv ====
/*
 * Testbench for the two-source video switch.
 * Source models: 640 strobes per line, 12 lines per frame, channel 0 strobes
 * every 2 cycles and channel 1 every 4. Each table row runs for a number of
 * channel 1 frames; the first check failure ends the run.
 * vdc_position of a row is applied half a channel 0 frame after the row starts.
 */
`timescale 1ns/1ps

module video_switch_tb import vswitch_pkg::*; ();

   localparam int CH1_FRAME = 640 * 4 * 12;  // Cycles per channel 1 frame
   localparam int POS_DELAY = CH1_FRAME / 4;  // Middle of a channel 0 frame
   localparam int NUM_ROWS  = 8;

   typedef struct packed {
      int   px;
      int   line;
      logic hb;
      logic vb;
      logic chk;  // Blanking is predictable for this strobe
   } tag_t;

   typedef struct packed {
      src_in_t s;
      tag_t    t;
   } hist_t;

   typedef struct packed {
      logic mode;
      logic wide;
      logic pos;
      logic en0;
      logic en1;
      int   frames;
      logic sel;
      logic dis;
      logic blue;
   } row_t;

   // mode wide pos en0 en1 frames | selected vga_disable blue
   row_t rows [NUM_ROWS] = '{
      '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 3, 1'b0, 1'b0, 1'b0},
      '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 2, 1'b0, 1'b0, 1'b0},
      '{1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 2, 1'b0, 1'b0, 1'b0},  // Position mid-frame
      '{1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 4, 1'b1, 1'b0, 1'b0},
      '{1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 2, 1'b1, 1'b0, 1'b0},
      '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 4, 1'b0, 1'b0, 1'b0},
      '{1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 3, 1'b1, 1'b1, 1'b1},  // Dead channel 1
      '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 5, 1'b0, 1'b0, 1'b0}
   };

   logic                clk_vdc;
   logic                pll_reset;
   logic                mode;
   logic                wide;
   logic                vdc_position;
   src_in_t             src [NUM_CHAN];
   vid_out_t            vid;
   logic                ce_pix;
   logic                selected;
   logic [NUM_CHAN-1:0] en;
   tag_t                tag [NUM_CHAN];
   hist_t               h1  [NUM_CHAN];
   hist_t               h2  [NUM_CHAN];
   int                  row_idx;
   time                 row_t0;
   logic                seen_blue;
   int                  blue_row;
   integer              seed;

   clk_gen u_clk_gen (
      .clk_vdc   (clk_vdc),
      .pll_reset (pll_reset)
   );

   video_switch DUT (
      .clk_vdc      (clk_vdc),
      .pll_reset    (pll_reset),
      .mode         (mode),
      .wide         (wide),
      .vdc_position (vdc_position),
      .src          (src),
      .vid          (vid),
      .ce_pix       (ce_pix),
      .selected     (selected)
   );

   function automatic hshift_t exp_shift(int k, logic w, logic p);
      hshift_t s;
      s.left  = w ? SHIFT_L_WIDE : SHIFT_L_NARROW;
      s.right = w ? SHIFT_R_WIDE : SHIFT_R_NARROW;
      if (k == 0) begin
         s.left  = s.left + (p ? POS1_L_OFS : POS_L_OFS);
         s.right = s.right + (p ? POS1_R_OFS : POS_R_OFS);
      end
      return s;
   endfunction

   task automatic report_error(string msg);
      $display("Error at %0t ns: %s", $time, msg);
      $display("sim failed");
      $fatal(1, "stopped at the first error");
   endtask

   initial begin : source_models
      int      cnt   [NUM_CHAN];
      int      px    [NUM_CHAN];
      int      ln    [NUM_CHAN];
      int      seen  [NUM_CHAN];
      logic    vs_ok [NUM_CHAN];
      color_t  rnd   [NUM_CHAN];
      int      arm;
      int      per;
      logic    pos_ref;
      hshift_t sh;
      seed    = 32'hb6e0_84a5;
      arm     = 0;
      pos_ref = 1'b0;
      for (int k = 0; k < NUM_CHAN; k++) begin
         src[k] = '0;
         tag[k] = '0;
         rnd[k] = '0;
      end
      forever begin
         @(posedge clk_vdc);
         // Channel 0 position is sampled two cycles after its vsync rise
         if (arm != 0) begin
            arm--;
            if (arm == 0) begin
               pos_ref = vdc_position;
            end
         end
         for (int k = 0; k < NUM_CHAN; k++) begin
            per = (k == 0) ? 2 : 4;
            if (pll_reset) begin
               cnt[k]   = 0;
               px[k]    = 0;
               ln[k]    = 0;
               seen[k]  = 0;
               vs_ok[k] = 1'b0;
               src[k]  <= '0;
               tag[k]  <= '0;
            end else if (cnt[k] != per - 1) begin
               cnt[k]++;
               src[k].ce <= 1'b0;
            end else begin
               cnt[k] = 0;
               if (px[k] == 0) begin
                  rnd[k] = color_t'($random(seed));
                  if (!en[k]) begin
                     seen[k]  = 0;
                     vs_ok[k] = 1'b0;
                  end else begin
                     if (seen[k] < 2) seen[k]++;
                     if (ln[k] == 0) vs_ok[k] = 1'b1;
                     if (k == 0 && ln[k] == 0) arm = 2;
                  end
               end
               sh = exp_shift(k, wide, pos_ref);
               src[k] <= '{hsync: en[k] && px[k] < 40,
                           vsync: en[k] && ln[k] == 0,
                           ce: 1'b1,
                           r: color_t'(px[k]) ^ rnd[k],
                           g: color_t'(ln[k] * 20 + px[k] / 16),
                           b: color_t'(px[k] + ln[k]) + rnd[k]};
               tag[k] <= '{px: px[k],
                           line: ln[k],
                           hb: px[k] < int'(sh.left) || px[k] >= 640 - int'(sh.right),
                           vb: ln[k] < VBLANK_LINES,
                           chk: seen[k] >= 2 && vs_ok[k] && ($time - row_t0 > 200)};
               px[k]++;
               if (px[k] == 640) begin
                  px[k] = 0;
                  ln[k] = (ln[k] == 11) ? 0 : ln[k] + 1;
               end
            end
         end
      end
   end

   // Source samples as the DUT sees them, two cycles back
   always @(posedge clk_vdc) begin
      for (int k = 0; k < NUM_CHAN; k++) begin
         h1[k] <= '{s: src[k], t: tag[k]};
         h2[k] <= h1[k];
      end
   end

   initial blue_row = -1;

   always @(negedge clk_vdc) begin : output_check
      hist_t e;
      if (row_idx != blue_row) begin
         blue_row   = row_idx;
         seen_blue <= 1'b0;
      end
      if (!pll_reset && $time - row_t0 > 100) begin
         if (DUT.u_out_switch.switching) begin
            assert (vid.r == '0 && vid.g == '0)
               else report_error("r or g not zero while switching");
            if (vid.b == BLUE_SCREEN) seen_blue <= 1'b1;
            assert (rows[row_idx].blue || vid.b == '0)
               else report_error($sformatf("b is %h while switching to a live source", vid.b));
         end else begin
            e = h2[selected];
            assert (ce_pix == e.s.ce)
               else report_error($sformatf("ce_pix %b, expected %b from the strobe 2 cycles earlier",
                                           ce_pix, e.s.ce));
            if (ce_pix) begin
               assert (vid.hsync == e.s.hsync && vid.vsync == e.s.vsync)
                  else report_error($sformatf("syncs %b%b, expected %b%b", vid.hsync,
                                              vid.vsync, e.s.hsync, e.s.vsync));
               assert (vid.r == e.s.r && vid.g == e.s.g && vid.b == e.s.b)
                  else report_error($sformatf("rgb %h%h%h, expected %h%h%h", vid.r, vid.g,
                                              vid.b, e.s.r, e.s.g, e.s.b));
               if (e.t.chk) begin
                  assert (vid.hblank == e.t.hb)
                     else report_error($sformatf("hblank %b at ch %0d pixel %0d, expected %b",
                                                 vid.hblank, selected, e.t.px, e.t.hb));
                  assert (vid.vblank == e.t.vb)
                     else report_error($sformatf("vblank %b at ch %0d line %0d, expected %b",
                                                 vid.vblank, selected, e.t.line, e.t.vb));
               end
            end
         end
      end
   end

   initial begin : stimulus
      mode         = 1'b0;
      wide         = 1'b0;
      vdc_position = 1'b0;
      en           = '1;
      row_idx      = 0;
      row_t0       = 0;
      @(negedge pll_reset);
      for (int r = 0; r < NUM_ROWS; r++) begin
         @(posedge clk_vdc);
         mode   <= rows[r].mode;
         wide   <= rows[r].wide;
         en     <= {rows[r].en1, rows[r].en0};
         row_idx = r;
         row_t0 <= $time;
         repeat (POS_DELAY) @(posedge clk_vdc);
         vdc_position <= rows[r].pos;
         repeat (rows[r].frames * CH1_FRAME - POS_DELAY) @(posedge clk_vdc);
         @(negedge clk_vdc);
         assert (selected == rows[r].sel)
            else report_error($sformatf("row %0d selected %b, expected %b", r, selected,
                                        rows[r].sel));
         assert (vid.vga_disable == rows[r].dis)
            else report_error($sformatf("row %0d vga_disable %b, expected %b", r,
                                        vid.vga_disable, rows[r].dis));
         assert (!rows[r].blue || seen_blue)
            else report_error($sformatf("row %0d blue screen missing while switching", r));
      end
      $display("sim passed");
      $finish;
   end

   initial begin : watchdog
      int total;
      total = 0;
      for (int r = 0; r < NUM_ROWS; r++) begin
         total += rows[r].frames;
      end
      repeat (total * CH1_FRAME * 2 + 100) @(posedge clk_vdc);
      $display("Timeout: the stimulus table did not finish in time");
      $display("sim failed");
      $fatal(1, "watchdog expired");
   end

endmodule
